// File: Bender.yml
package:
  name: ooo_core

sources:
  - files:
      - logic/ooo_pkg.sv
      - logic/dispatch_regfile.sv
      - logic/reservation_station.sv
      - logic/cdb_arbiter.sv
      - logic/ooo_core.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/ooo_core_tb.sv

// File: logic/cdb_arbiter.sv
`timescale 1ns/1ps

module cdb_arbiter #(
    parameter int  NUM_STATIONS = 4,
    localparam int TAG_W        = $clog2(NUM_STATIONS)
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [NUM_STATIONS-1:0]                ready,
    input  logic [NUM_STATIONS*ooo_pkg::XLEN-1:0]  result,
    output logic [NUM_STATIONS-1:0]                grant,
    output logic                                   cdb_valid,
    output logic [TAG_W-1:0]                       cdb_tag,
    output logic [ooo_pkg::XLEN-1:0]               cdb_data
);

    logic [TAG_W-1:0] win_tag;
    logic             win_valid;

    // fixed priority, lowest index wins
    always_comb begin
        win_tag   = '0;
        win_valid = 1'b0;
        for (int i = NUM_STATIONS - 1; i >= 0; i--) begin
            if (ready[i]) begin
                win_tag   = TAG_W'(i);
                win_valid = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (win_valid) begin
            grant[win_tag] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cdb_valid <= 1'b0;
        end else begin
            cdb_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            cdb_tag  <= win_tag;
            cdb_data <= result[win_tag*ooo_pkg::XLEN +: ooo_pkg::XLEN];
        end
    end

endmodule

// File: logic/dispatch_regfile.sv
`timescale 1ns/1ps

module dispatch_regfile #(
    parameter int  NUM_STATIONS = 4,
    localparam int TAG_W        = $clog2(NUM_STATIONS)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           issue_valid,
    input  ooo_pkg::alu_op_e               issue_op,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] issue_rd,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] issue_rs1,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] issue_rs2,
    input  logic [ooo_pkg::XLEN-1:0]       issue_imm,
    input  logic                           issue_use_imm,
    input  logic [NUM_STATIONS-1:0]        busy,
    input  logic                           cdb_valid,
    input  logic [TAG_W-1:0]               cdb_tag,
    input  logic [ooo_pkg::XLEN-1:0]       cdb_data,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] dbg_addr,
    output logic                           issue_ready,
    output logic [NUM_STATIONS-1:0]        load,
    output ooo_pkg::alu_op_e               st_op,
    output logic [ooo_pkg::XLEN-1:0]       st_a,
    output logic                           st_a_pending,
    output logic [TAG_W-1:0]               st_a_tag,
    output logic [ooo_pkg::XLEN-1:0]       st_b,
    output logic                           st_b_pending,
    output logic [TAG_W-1:0]               st_b_tag,
    output logic [ooo_pkg::XLEN-1:0]       dbg_data,
    output logic                           idle
);

    localparam int NUM_REGS = 2 ** ooo_pkg::REG_ADDR_W;

    logic [ooo_pkg::XLEN-1:0] value [NUM_REGS];
    logic [NUM_REGS-1:0]      pend;
    logic [TAG_W-1:0]         tag [NUM_REGS];    // producing station per register
    logic [TAG_W-1:0]         free_tag;
    logic                     fire;

    // register read with rename lookup and bus bypass
    function automatic void lookup(
        input  logic [ooo_pkg::REG_ADDR_W-1:0] r,
        output logic [ooo_pkg::XLEN-1:0]       v,
        output logic                           p,
        output logic [TAG_W-1:0]               t
    );
        v = value[r];
        p = 1'b0;
        t = tag[r];
        if (pend[r]) begin
            if (cdb_valid && cdb_tag == tag[r]) begin
                v = cdb_data;    // result lands this cycle
            end else begin
                p = 1'b1;
            end
        end
    endfunction

    // lowest free station
    always_comb begin
        free_tag = '0;
        for (int i = NUM_STATIONS - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_tag = TAG_W'(i);
            end
        end
    end

    assign issue_ready = ~&busy;
    assign fire        = issue_valid && issue_ready;

    always_comb begin
        load = '0;
        if (fire) begin
            load[free_tag] = 1'b1;
        end
    end

    assign st_op = issue_op;

    always_comb begin
        lookup(issue_rs1, st_a, st_a_pending, st_a_tag);
        lookup(issue_rs2, st_b, st_b_pending, st_b_tag);
        if (issue_use_imm) begin
            st_b         = issue_imm;
            st_b_pending = 1'b0;
            st_b_tag     = '0;
        end
    end

    // write-back first, rename after so a same-cycle issue wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                value[r] <= '0;
                tag[r]   <= '0;
            end
        end else begin
            if (cdb_valid) begin
                for (int r = 1; r < NUM_REGS; r++) begin
                    if (pend[r] && tag[r] == cdb_tag) begin    // youngest writer only
                        value[r] <= cdb_data;
                        pend[r]  <= 1'b0;
                    end
                end
            end
            if (fire && issue_rd != '0) begin
                pend[issue_rd] <= 1'b1;
                tag[issue_rd]  <= free_tag;
            end
        end
    end

    assign dbg_data = value[dbg_addr];
    assign idle     = ~|busy && !cdb_valid;

endmodule

// File: logic/ooo_core.sv
`timescale 1ns/1ps

module ooo_core #(
    parameter int  NUM_STATIONS = 4,
    localparam int TAG_W        = $clog2(NUM_STATIONS)
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           issue_valid,
    input  ooo_pkg::alu_op_e               issue_op,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] issue_rd,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] issue_rs1,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] issue_rs2,
    input  logic [ooo_pkg::XLEN-1:0]       issue_imm,
    input  logic                           issue_use_imm,
    output logic                           issue_ready,
    input  logic [ooo_pkg::REG_ADDR_W-1:0] dbg_addr,
    output logic [ooo_pkg::XLEN-1:0]       dbg_data,
    output logic                           idle,
    output logic                           cdb_valid,
    output logic [TAG_W-1:0]               cdb_tag,
    output logic [ooo_pkg::XLEN-1:0]       cdb_data
);

    logic [NUM_STATIONS-1:0]               load;
    logic [NUM_STATIONS-1:0]               busy;
    logic [NUM_STATIONS-1:0]               ready;
    logic [NUM_STATIONS-1:0]               grant;
    logic [NUM_STATIONS*ooo_pkg::XLEN-1:0] result;    // station i at word i
    ooo_pkg::alu_op_e                      st_op;
    logic [ooo_pkg::XLEN-1:0]              st_a;
    logic                                  st_a_pending;
    logic [TAG_W-1:0]                      st_a_tag;
    logic [ooo_pkg::XLEN-1:0]              st_b;
    logic                                  st_b_pending;
    logic [TAG_W-1:0]                      st_b_tag;

    dispatch_regfile #(
        .NUM_STATIONS (NUM_STATIONS)
    ) dispatch_regfile_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_use_imm (issue_use_imm),
        .busy          (busy),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data),
        .dbg_addr      (dbg_addr),
        .issue_ready   (issue_ready),
        .load          (load),
        .st_op         (st_op),
        .st_a          (st_a),
        .st_a_pending  (st_a_pending),
        .st_a_tag      (st_a_tag),
        .st_b          (st_b),
        .st_b_pending  (st_b_pending),
        .st_b_tag      (st_b_tag),
        .dbg_data      (dbg_data),
        .idle          (idle)
    );

    for (genvar i = 0; i < NUM_STATIONS; i++) begin : gen_station
        reservation_station #(
            .TAG_W      (TAG_W),
            .STATION_ID (i)
        ) station_inst (
            .clk       (clk),
            .rst_n     (rst_n),
            .load      (load[i]),
            .op        (st_op),
            .a         (st_a),
            .a_pending (st_a_pending),
            .a_tag     (st_a_tag),
            .b         (st_b),
            .b_pending (st_b_pending),
            .b_tag     (st_b_tag),
            .cdb_valid (cdb_valid),
            .cdb_tag   (cdb_tag),
            .cdb_data  (cdb_data),
            .grant     (grant[i]),
            .busy      (busy[i]),
            .ready     (ready[i]),
            .result    (result[i*ooo_pkg::XLEN +: ooo_pkg::XLEN])
        );
    end

    cdb_arbiter #(
        .NUM_STATIONS (NUM_STATIONS)
    ) cdb_arbiter_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ready     (ready),
        .result    (result),
        .grant     (grant),
        .cdb_valid (cdb_valid),
        .cdb_tag   (cdb_tag),
        .cdb_data  (cdb_data)
    );

endmodule

// File: logic/ooo_pkg.sv
package ooo_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;    // x0..x31

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_OR  = 3'd3,
        OP_XOR = 3'd4,
        OP_SLL = 3'd5,
        OP_SRL = 3'd6,
        OP_SLT = 3'd7
    } alu_op_e;

    function automatic logic [XLEN-1:0] alu_eval(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] res;
        logic            lt;
        lt = $signed(a) < $signed(b);
        case (op)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SLL:  res = a << b[4:0];    // shamt from low bits only
            OP_SRL:  res = a >> b[4:0];
            OP_SLT:  res = {{(XLEN-1){1'b0}}, lt};
            default: res = '0;
        endcase
        return res;
    endfunction

endpackage

// File: logic/reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int TAG_W      = 2,
    parameter int STATION_ID = 0
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,
    input  ooo_pkg::alu_op_e         op,
    input  logic [ooo_pkg::XLEN-1:0] a,
    input  logic                     a_pending,
    input  logic [TAG_W-1:0]         a_tag,
    input  logic [ooo_pkg::XLEN-1:0] b,
    input  logic                     b_pending,
    input  logic [TAG_W-1:0]         b_tag,
    input  logic                     cdb_valid,
    input  logic [TAG_W-1:0]         cdb_tag,
    input  logic [ooo_pkg::XLEN-1:0] cdb_data,
    input  logic                     grant,
    output logic                     busy,
    output logic                     ready,
    output logic [ooo_pkg::XLEN-1:0] result
);

    ooo_pkg::alu_op_e         op_q;
    logic [ooo_pkg::XLEN-1:0] a_q;
    logic [ooo_pkg::XLEN-1:0] b_q;
    logic [TAG_W-1:0]         a_tag_q;
    logic [TAG_W-1:0]         b_tag_q;
    logic                     a_wait;
    logic                     b_wait;
    logic                     a_wake;
    logic                     b_wake;

    // snoop the bus for pending operands
    assign a_wake = busy && a_wait && cdb_valid && cdb_tag == a_tag_q;
    assign b_wake = busy && b_wait && cdb_valid && cdb_tag == b_tag_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            a_wait <= 1'b0;
            b_wait <= 1'b0;
        end else if (load) begin
            busy   <= 1'b1;
            a_wait <= a_pending;
            b_wait <= b_pending;
        end else begin
            if (grant) begin
                busy <= 1'b0;    // result goes onto the bus at this edge
            end
            if (a_wake) begin
                a_wait <= 1'b0;
            end
            if (b_wake) begin
                b_wait <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            op_q    <= op;
            a_q     <= a;
            b_q     <= b;
            a_tag_q <= a_tag;
            b_tag_q <= b_tag;
        end else begin
            if (a_wake) begin
                a_q <= cdb_data;
            end
            if (b_wake) begin
                b_q <= cdb_data;
            end
        end
    end

    assign ready  = busy && !a_wait && !b_wait;
    assign result = ooo_pkg::alu_eval(op_q, a_q, b_q);

endmodule

// File: project.f
+incdir+tb
logic/ooo_pkg.sv
logic/dispatch_regfile.sv
logic/reservation_station.sv
logic/cdb_arbiter.sv
logic/ooo_core.sv
tb/ooo_core_tb.sv

// File: tb/ooo_core_ref.svh
`ifndef OOO_CORE_REF_SVH
`define OOO_CORE_REF_SVH

// lcg step with numerical recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// independent model of the ALU rules
function automatic logic [31:0] ref_alu(
    input ooo_pkg::alu_op_e op,
    input logic [31:0]      a,
    input logic [31:0]      b
);
    logic [31:0] res;
    logic [4:0]  shamt;
    shamt = b[4:0];
    res   = 32'd0;
    case (op)
        ooo_pkg::OP_ADD: res = a + b;
        ooo_pkg::OP_SUB: res = a + ~b + 32'd1;
        ooo_pkg::OP_AND: res = a & b;
        ooo_pkg::OP_OR:  res = a | b;
        ooo_pkg::OP_XOR: res = a ^ b;
        ooo_pkg::OP_SLL: res = a << shamt;
        ooo_pkg::OP_SRL: res = a >> shamt;
        ooo_pkg::OP_SLT: begin
            if (a[31] != b[31]) begin
                res = {31'd0, a[31]};    // on sign mismatch the negative one is smaller
            end else begin
                res = {31'd0, a < b};
            end
        end
        default: res = 32'd0;
    endcase
    return res;
endfunction

// replay the whole issued list in program order
function automatic void run_reference();
    logic [31:0] a;
    logic [31:0] b;
    for (int r = 0; r < 32; r++) begin
        ref_regs[r] = 32'd0;
    end
    foreach (prog[i]) begin
        a = ref_regs[prog[i].rs1];
        b = prog[i].use_imm ? prog[i].imm : ref_regs[prog[i].rs2];
        if (prog[i].rd != 5'd0) begin
            ref_regs[prog[i].rd] = ref_alu(prog[i].op, a, b);
        end
    end
endfunction

task automatic compare_values(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected) begin
        error_count++;
        $display("ERR %s: got 0x%08h expected 0x%08h", name, got, expected);
        abort_run("value mismatch against the reference model");
    end
endtask

`endif

// File: tb/ooo_core_tb.sv
`timescale 1ns/1ps

module ooo_core_tb;

    localparam int NUM_STATIONS = 4;
    localparam int TAG_W        = $clog2(NUM_STATIONS);
    localparam int DRIVE_DELAY  = 1;
    localparam int TOTAL_INSTR  = 12 + 12 + 5 + 16 + 300;
    localparam int CYCLE_LIMIT  = 20 * TOTAL_INSTR + 200;

    typedef struct packed {
        ooo_pkg::alu_op_e op;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [31:0]      imm;
        logic             use_imm;
    } instr_t;

    logic             clk;
    logic             rst_n;
    logic             issue_valid;
    ooo_pkg::alu_op_e issue_op;
    logic [4:0]       issue_rd;
    logic [4:0]       issue_rs1;
    logic [4:0]       issue_rs2;
    logic [31:0]      issue_imm;
    logic             issue_use_imm;
    logic             issue_ready;
    logic [4:0]       dbg_addr;
    logic [31:0]      dbg_data;
    logic             idle;
    logic             cdb_valid;
    logic [TAG_W-1:0] cdb_tag;
    logic [31:0]      cdb_data;

    instr_t      prog[$];    // everything accepted so far, in order
    logic [31:0] ref_regs [32];
    logic [31:0] rng_state;
    int          error_count;
    int          cycle_count;
    int          checks_requested;
    int          checks_done;
    logic        stall_seen;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    `include "ooo_core_ref.svh"

    ooo_core #(
        .NUM_STATIONS (NUM_STATIONS)
    ) ooo_core_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_rd      (issue_rd),
        .issue_rs1     (issue_rs1),
        .issue_rs2     (issue_rs2),
        .issue_imm     (issue_imm),
        .issue_use_imm (issue_use_imm),
        .issue_ready   (issue_ready),
        .dbg_addr      (dbg_addr),
        .dbg_data      (dbg_data),
        .idle          (idle),
        .cdb_valid     (cdb_valid),
        .cdb_tag       (cdb_tag),
        .cdb_data      (cdb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // called at posedge + DRIVE_DELAY, returns at the same point after the taking edge
    task automatic issue_instr(input ooo_pkg::alu_op_e op, input logic [4:0] rd,
                               input logic [4:0] rs1, input logic [4:0] rs2,
                               input logic [31:0] imm, input logic use_imm);
        instr_t ins;
        logic   taken;
        ins = '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm, use_imm: use_imm};
        issue_valid   = 1'b1;
        issue_op      = op;
        issue_rd      = rd;
        issue_rs1     = rs1;
        issue_rs2     = rs2;
        issue_imm     = imm;
        issue_use_imm = use_imm;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = issue_ready;
            if (!taken) begin
                stall_seen = 1'b1;
            end
            @(posedge clk);
            #DRIVE_DELAY;
        end
        issue_valid = 1'b0;
        prog.push_back(ins);
    endtask

    function automatic instr_t random_instr();
        instr_t      ins;
        logic [31:0] r;
        rng_state   = lcg_next(rng_state);
        r           = rng_state;
        ins.op      = ooo_pkg::alu_op_e'(r[30:28]);
        ins.use_imm = r[31];
        ins.rd      = {1'b0, r[27:24]};    // few registers, more hazards
        ins.rs1     = {1'b0, r[23:20]};
        ins.rs2     = {1'b0, r[19:16]};
        rng_state   = lcg_next(rng_state);
        ins.imm     = rng_state;
        return ins;
    endfunction

    // returns at posedge + DRIVE_DELAY once the registers are compared
    task automatic request_check();
        checks_requested++;
        wait (checks_done == checks_requested);
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // compare all registers once the core has drained
    initial begin
        checks_done = 0;
        forever begin
            wait (checks_requested > checks_done);
            @(negedge clk);
            while (!idle) begin
                @(negedge clk);
            end
            run_reference();
            for (int r = 0; r < 32; r++) begin
                @(posedge clk);
                #DRIVE_DELAY;
                dbg_addr = 5'(r);
                @(negedge clk);
                compare_values($sformatf("dbg_data[x%0d]", r), dbg_data, ref_regs[r]);
            end
            checks_done++;
        end
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        abort_run("timeout, the core did not drain within the cycle limit");
    end

    initial begin
        instr_t ins;
        rst_n            = 1'b0;
        issue_valid      = 1'b0;
        issue_op         = ooo_pkg::OP_ADD;
        issue_rd         = 5'd0;
        issue_rs1        = 5'd0;
        issue_rs2        = 5'd0;
        issue_imm        = 32'd0;
        issue_use_imm    = 1'b0;
        dbg_addr         = 5'd0;
        rng_state        = 32'hb88e;
        error_count      = 0;
        checks_requested = 0;
        stall_seen       = 1'b0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;

        @(negedge clk);
        compare_values("issue_ready", issue_ready, 1);
        compare_values("idle", idle, 1);
        compare_values("cdb_valid", cdb_valid, 0);
        @(posedge clk);
        #DRIVE_DELAY;
        request_check();

        // lone op on an empty core goes to station 0 and reaches the bus two edges later
        issue_instr(ooo_pkg::OP_ADD, 5'd20, 5'd0, 5'd0, 32'hf0f0_1234, 1'b1);
        @(negedge clk);
        compare_values("cdb_valid", cdb_valid, 0);
        @(negedge clk);
        compare_values("cdb_valid", cdb_valid, 1);
        compare_values("cdb_tag", cdb_tag, 0);
        compare_values("cdb_data", cdb_data, 32'hf0f0_1234);
        @(posedge clk);
        #DRIVE_DELAY;

        // every opcode against immediates, plus a dropped write to x0
        issue_instr(ooo_pkg::OP_ADD, 5'd21, 5'd0, 5'd0, 32'h8000_0003, 1'b1);
        for (int k = 0; k < 8; k++) begin
            issue_instr(ooo_pkg::alu_op_e'(k), 5'(1 + k), 5'd20, 5'd0, 32'h24 + k, 1'b1);
        end
        issue_instr(ooo_pkg::OP_SLT, 5'd9, 5'd21, 5'd20, 32'd0, 1'b0);
        issue_instr(ooo_pkg::OP_ADD, 5'd0, 5'd20, 5'd0, 32'd5, 1'b1);
        request_check();

        for (int k = 0; k < 12; k++) begin
            issue_instr(ooo_pkg::alu_op_e'(k % 8), 5'(5 + k % 3),
                        (k == 0) ? 5'd20 : 5'(5 + (k - 1) % 3),
                        5'd21, 32'h13 * (k + 1), (k % 2) == 0);
        end
        request_check();

        // slow chain into x10, then a quick x10 write that must win
        issue_instr(ooo_pkg::OP_ADD, 5'd14, 5'd0, 5'd0, 32'd7, 1'b1);
        issue_instr(ooo_pkg::OP_SLL, 5'd15, 5'd14, 5'd0, 32'd3, 1'b1);
        issue_instr(ooo_pkg::OP_ADD, 5'd10, 5'd15, 5'd14, 32'd0, 1'b0);
        issue_instr(ooo_pkg::OP_ADD, 5'd10, 5'd0, 5'd0, 32'h77, 1'b1);
        issue_instr(ooo_pkg::OP_ADD, 5'd16, 5'd10, 5'd0, 32'd1, 1'b1);
        request_check();

        stall_seen = 1'b0;
        for (int k = 0; k < 16; k++) begin
            issue_instr(ooo_pkg::OP_ADD, 5'd12, 5'd12, 5'd12, 32'h101 * (k + 1), k % 4 != 3);
        end
        compare_values("stall_seen", stall_seen, 1);
        request_check();

        for (int k = 0; k < 300; k++) begin
            ins = random_instr();
            issue_instr(ins.op, ins.rd, ins.rs1, ins.rs2, ins.imm, ins.use_imm);
        end
        request_check();

        if (error_count == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            abort_run("checks reported mismatches");
        end
    end

endmodule
